// File: mem_cfg.svh
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// ####################
// Data RAM
// ####################

// Size of the data RAM in 32-bit words.
`define MEM_DEPTH_WORDS 256

// Extra stall cycles added to every RAM read or write.
// Zero gives a single-cycle memory.
`define MEM_WAIT_STATES 1

`endif

// File: cpu_pkg.sv
package cpu_pkg;

	// Widths with a meaning.
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	// Bit n enables byte lane n, bits 8n+7 to 8n.
	typedef logic [3:0]  byte_sel_t;

	// ####################
	// Operations
	// ####################

	typedef enum logic [3:0] {
		OP_NOP,
		OP_LB,
		OP_LBU,
		OP_LH,
		OP_LHU,
		OP_LW,
		OP_LWL,
		OP_LWR,
		OP_LL,
		OP_SB,
		OP_SH,
		OP_SW,
		OP_SC,
		OP_ALU
	} oper_t;

	// Memory request held in the EX/MEM latch.
	typedef struct packed {
		logic      ce;
		logic      we;
		word_t     addr;
		byte_sel_t sel;
		word_t     wdata;
	} mem_access_req_t;

	// Register file write request.
	typedef struct packed {
		logic      we;
		reg_addr_t waddr;
		word_t     wdata;
	} reg_write_req_t;

	// ####################
	// Data bus
	// ####################

	typedef struct packed {
		word_t     address;
		logic      read;
		logic      write;
		byte_sel_t mask;
		word_t     data_wr;
	} bus_req_t;

	typedef struct packed {
		word_t data_rd;
		logic  stall;
	} bus_resp_t;

endpackage

// File: mem_addr_gen.sv
`timescale 1ns/1ps

module mem_addr_gen (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     stall_i,
	input  logic                     valid_i,
	input  cpu_pkg::oper_t           op_i,
	input  cpu_pkg::word_t           base_i,
	input  logic [15:0]              offset_i,
	input  cpu_pkg::word_t           rt_i,
	input  cpu_pkg::reg_addr_t       waddr_i,
	output cpu_pkg::oper_t           op_o,
	output cpu_pkg::mem_access_req_t req_o,
	output cpu_pkg::reg_write_req_t  wr_o
);

	import cpu_pkg::*;

	oper_t           op_d;
	word_t           eff_addr;
	logic [1:0]      byte_off;
	mem_access_req_t req_d;
	reg_write_req_t  wr_d;

	assign op_d     = valid_i ? op_i : OP_NOP;
	assign eff_addr = base_i + {{16{offset_i[15]}}, offset_i};
	assign byte_off = eff_addr[1:0];

	// ####################
	// Decode
	// ####################

	// Halfword and word accesses drop the misaligned address bits.
	always_comb
	begin
		req_d.ce    = 1'b0;
		req_d.we    = 1'b0;
		req_d.addr  = eff_addr;
		req_d.sel   = 4'b1111;
		req_d.wdata = '0;
		wr_d.we     = 1'b0;
		wr_d.waddr  = waddr_i;
		wr_d.wdata  = '0;
		case (op_d)
			OP_LB, OP_LBU:
			begin
				req_d.ce = 1'b1;
				wr_d.we  = 1'b1;
			end
			OP_LH, OP_LHU:
			begin
				req_d.ce   = 1'b1;
				req_d.addr = {eff_addr[31:1], 1'b0};
				wr_d.we    = 1'b1;
			end
			OP_LW, OP_LL:
			begin
				req_d.ce   = 1'b1;
				req_d.addr = {eff_addr[31:2], 2'b00};
				wr_d.we    = 1'b1;
			end
			OP_LWL:
			begin
				req_d.ce    = 1'b1;
				req_d.sel   = 4'b1111 << ~byte_off;
				req_d.wdata = rt_i;
				wr_d.we     = 1'b1;
			end
			OP_LWR:
			begin
				req_d.ce    = 1'b1;
				req_d.sel   = 4'b1111 << byte_off;
				req_d.wdata = rt_i;
				wr_d.we     = 1'b1;
			end
			OP_SB:
			begin
				req_d.ce    = 1'b1;
				req_d.we    = 1'b1;
				req_d.sel   = 4'b0001 << byte_off;
				req_d.wdata = {4{rt_i[7:0]}};
			end
			OP_SH:
			begin
				req_d.ce    = 1'b1;
				req_d.we    = 1'b1;
				req_d.addr  = {eff_addr[31:1], 1'b0};
				req_d.sel   = 4'b0011 << {eff_addr[1], 1'b0};
				req_d.wdata = {2{rt_i[15:0]}};
			end
			OP_SW, OP_SC:
			begin
				req_d.ce    = 1'b1;
				req_d.we    = 1'b1;
				req_d.addr  = {eff_addr[31:2], 2'b00};
				req_d.wdata = rt_i;
				wr_d.we     = (op_d == OP_SC);
			end
			// result of a non-memory op arrives on rt
			OP_ALU:
			begin
				wr_d.we    = 1'b1;
				wr_d.wdata = rt_i;
			end
			default:
			begin
				req_d.sel = 4'b0000;
			end
		endcase
	end

	// EX/MEM latch.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			op_o     <= OP_NOP;
			req_o.ce <= 1'b0;
			req_o.we <= 1'b0;
			wr_o.we  <= 1'b0;
		end
		else if (!stall_i)
		begin
			op_o  <= op_d;
			req_o <= req_d;
			wr_o  <= wr_d;
		end
	end

endmodule

// File: cpu_mem.sv
`timescale 1ns/1ps

module cpu_mem (
	input  logic                     rst,
	input  logic                     ll_bit_i,
	input  cpu_pkg::oper_t           op_i,
	input  cpu_pkg::mem_access_req_t memory_req_i,
	input  cpu_pkg::reg_write_req_t  wr_i,
	output cpu_pkg::reg_write_req_t  wr_o,
	output cpu_pkg::bus_req_t        bus_req_o,
	input  cpu_pkg::bus_resp_t       bus_resp_i,
	output logic                     stall_req_o
);

	import cpu_pkg::*;

	logic [1:0] addr_offset;
	logic [4:0] rd_shamt;
	logic [4:0] lwl_shamt;
	byte_sel_t  merge_sel;
	word_t      merge_mask;
	word_t      aligned_data_rd;
	word_t      unaligned_data_rd;
	word_t      unaligned_word;
	word_t      sign_ext_byte;
	word_t      sign_ext_half;
	word_t      zero_ext_byte;
	word_t      zero_ext_half;

	assign stall_req_o = bus_resp_i.stall;

	// ####################
	// Load alignment
	// ####################

	assign addr_offset     = memory_req_i.addr[1:0];
	assign rd_shamt        = {addr_offset, 3'b000};
	assign lwl_shamt       = {~addr_offset, 3'b000};
	assign aligned_data_rd = bus_resp_i.data_rd >> rd_shamt;

	assign sign_ext_byte = {{24{aligned_data_rd[7]}}, aligned_data_rd[7:0]};
	assign sign_ext_half = {{16{aligned_data_rd[15]}}, aligned_data_rd[15:0]};
	assign zero_ext_byte = {24'b0, aligned_data_rd[7:0]};
	assign zero_ext_half = {16'b0, aligned_data_rd[15:0]};

	// LWL fills the top lanes of rt, LWR the bottom ones.
	assign unaligned_data_rd = (op_i == OP_LWL) ? (bus_resp_i.data_rd << lwl_shamt)
	                                            : aligned_data_rd;

	// LWR sel names memory lanes, shifted down to register lanes here.
	assign merge_sel  = (op_i == OP_LWR) ? (memory_req_i.sel >> addr_offset)
	                                     : memory_req_i.sel;
	assign merge_mask = {{8{merge_sel[3]}}, {8{merge_sel[2]}},
	                     {8{merge_sel[1]}}, {8{merge_sel[0]}}};

	// Request wdata carries rt for LWL and LWR.
	assign unaligned_word = (memory_req_i.wdata & ~merge_mask) |
	                        (unaligned_data_rd & merge_mask);

	// ####################
	// Bus and result
	// ####################

	always_comb
	begin
		if (rst)
		begin
			wr_o      = '0;
			bus_req_o = '0;
		end
		else if (memory_req_i.ce)
		begin
			bus_req_o.address = {memory_req_i.addr[31:2], 2'b00};
			bus_req_o.mask    = memory_req_i.sel;
			wr_o.waddr        = wr_i.waddr;
			if (memory_req_i.we)
			begin
				bus_req_o.read    = 1'b0;
				bus_req_o.write   = 1'b1;
				bus_req_o.data_wr = memory_req_i.wdata;
				if (op_i == OP_SC)
				begin
					// Store only while the link holds.
					bus_req_o.write = ll_bit_i;
					wr_o.we         = wr_i.we;
					wr_o.wdata      = {31'b0, ll_bit_i};
				end
				else
				begin
					wr_o.we    = 1'b0;
					wr_o.wdata = '0;
				end
			end
			else
			begin
				bus_req_o.read    = 1'b1;
				bus_req_o.write   = 1'b0;
				bus_req_o.data_wr = '0;
				wr_o.we           = wr_i.we;
				case (op_i)
					OP_LB:          wr_o.wdata = sign_ext_byte;
					OP_LBU:         wr_o.wdata = zero_ext_byte;
					OP_LH:          wr_o.wdata = sign_ext_half;
					OP_LHU:         wr_o.wdata = zero_ext_half;
					OP_LWL, OP_LWR: wr_o.wdata = unaligned_word;
					default:        wr_o.wdata = aligned_data_rd;
				endcase
			end
		end
		else
		begin
			wr_o      = wr_i;
			bus_req_o = '0;
		end
	end

endmodule

// File: data_sram.sv
`timescale 1ns/1ps
`include "mem_cfg.svh"

module data_sram (
	input  logic               clk,
	input  logic               rst,
	input  cpu_pkg::bus_req_t  bus_req_i,
	output cpu_pkg::bus_resp_t bus_resp_o
);

	import cpu_pkg::*;

	localparam int ADDR_W = $clog2(`MEM_DEPTH_WORDS);
	localparam int CNT_W  = $clog2(`MEM_WAIT_STATES + 2);
	localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(`MEM_WAIT_STATES);

	word_t             mem [`MEM_DEPTH_WORDS];
	logic [ADDR_W-1:0] word_idx;
	logic [CNT_W-1:0]  wait_cnt;
	logic              access;
	logic              stall;

	assign word_idx = bus_req_i.address[ADDR_W+1:2];
	assign access   = bus_req_i.read | bus_req_i.write;

	// Stall until the counter has covered the wait states.
	assign stall = access && (wait_cnt != WAIT_LAST);

	always_ff @(posedge clk)
	begin
		if (rst)
			wait_cnt <= '0;
		else if (stall)
			wait_cnt <= wait_cnt + 1'b1;
		else
			wait_cnt <= '0;
	end

	// Byte-masked write on the completing cycle.
	always_ff @(posedge clk)
	begin
		if (bus_req_i.write && !stall)
		begin
			for (int lane = 0; lane < 4; lane++)
			begin
				if (bus_req_i.mask[lane])
					mem[word_idx][lane*8 +: 8] <= bus_req_i.data_wr[lane*8 +: 8];
			end
		end
	end

	assign bus_resp_o.data_rd = mem[word_idx];
	assign bus_resp_o.stall   = stall;

endmodule

// File: mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    stall_i,
	input  cpu_pkg::oper_t          op_i,
	input  cpu_pkg::reg_write_req_t wr_i,
	output cpu_pkg::reg_write_req_t wb_o,
	output logic                    ll_bit_o
);

	import cpu_pkg::*;

	// MEM/WB latch, a bubble while memory stalls.
	always_ff @(posedge clk)
	begin
		if (rst)
			wb_o.we <= 1'b0;
		else if (stall_i)
			wb_o.we <= 1'b0;
		else
			wb_o <= wr_i;
	end

	// LL bit.
	// Set as an LL retires, cleared as an SC retires.
	always_ff @(posedge clk)
	begin
		if (rst)
			ll_bit_o <= 1'b0;
		else if (!stall_i)
		begin
			if (op_i == OP_LL)
				ll_bit_o <= 1'b1;
			else if (op_i == OP_SC)
				ll_bit_o <= 1'b0;
		end
	end

endmodule

// File: mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top (
	input  logic               clk,
	input  logic               rst,
	input  logic               valid_i,
	input  cpu_pkg::oper_t     op_i,
	input  cpu_pkg::word_t     base_i,
	input  logic [15:0]        offset_i,
	input  cpu_pkg::word_t     rt_i,
	input  cpu_pkg::reg_addr_t waddr_i,
	output logic               stall_o,
	output logic               wb_we_o,
	output cpu_pkg::reg_addr_t wb_waddr_o,
	output cpu_pkg::word_t     wb_wdata_o,
	output logic               ll_bit_o
);

	import cpu_pkg::*;

	oper_t           ex_mem_op;
	mem_access_req_t ex_mem_req;
	reg_write_req_t  ex_mem_wr;
	reg_write_req_t  mem_wr;
	reg_write_req_t  wb;
	bus_req_t        bus_req;
	bus_resp_t       bus_resp;
	logic            stall;
	logic            ll_bit;

	mem_addr_gen mem_addr_gen_inst (
		.clk     (clk),
		.rst     (rst),
		.stall_i (stall),
		.valid_i (valid_i),
		.op_i    (op_i),
		.base_i  (base_i),
		.offset_i(offset_i),
		.rt_i    (rt_i),
		.waddr_i (waddr_i),
		.op_o    (ex_mem_op),
		.req_o   (ex_mem_req),
		.wr_o    (ex_mem_wr)
	);

	cpu_mem cpu_mem_inst (
		.rst         (rst),
		.ll_bit_i    (ll_bit),
		.op_i        (ex_mem_op),
		.memory_req_i(ex_mem_req),
		.wr_i        (ex_mem_wr),
		.wr_o        (mem_wr),
		.bus_req_o   (bus_req),
		.bus_resp_i  (bus_resp),
		.stall_req_o (stall)
	);

	data_sram data_sram_inst (
		.clk       (clk),
		.rst       (rst),
		.bus_req_i (bus_req),
		.bus_resp_o(bus_resp)
	);

	mem_wb_stage mem_wb_stage_inst (
		.clk     (clk),
		.rst     (rst),
		.stall_i (stall),
		.op_i    (ex_mem_op),
		.wr_i    (mem_wr),
		.wb_o    (wb),
		.ll_bit_o(ll_bit)
	);

	assign stall_o    = stall;
	assign wb_we_o    = wb.we;
	assign wb_waddr_o = wb.waddr;
	assign wb_wdata_o = wb.wdata;
	assign ll_bit_o   = ll_bit;

endmodule

// File: mem_subsys_assertions.sv
`timescale 1ns/1ps

module mem_subsys_assertions (
	input logic              clk_i,
	input logic              rst_i,
	input cpu_pkg::bus_req_t bus_req_i,
	input logic              stall_i,
	input logic              wb_we_i
);

	int fail_count = 0;

	no_read_write: assert property (@(posedge clk_i) disable iff (rst_i)
		!(bus_req_i.read && bus_req_i.write))
	else
	begin
		fail_count++;
		$error("bus read and write high in the same cycle");
	end

	word_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
		bus_req_i.address[1:0] == 2'b00)
	else
	begin
		fail_count++;
		$error("bus address not word aligned");
	end

	// Request held for the whole stall.
	stable_in_stall: assert property (@(posedge clk_i) disable iff (rst_i)
		stall_i |=> $stable(bus_req_i))
	else
	begin
		fail_count++;
		$error("bus request changed during a stall");
	end

	quiet_after_reset: assert property (@(posedge clk_i) rst_i |=> !wb_we_i)
	else
	begin
		fail_count++;
		$error("write-back enable high right after reset");
	end

	bubble_after_stall: assert property (@(posedge clk_i) disable iff (rst_i)
		stall_i |=> !wb_we_i)
	else
	begin
		fail_count++;
		$error("stall not followed by a write-back bubble");
	end

endmodule

bind mem_subsys_top mem_subsys_assertions mem_subsys_assertions_inst (
	.clk_i    (clk),
	.rst_i    (rst),
	.bus_req_i(bus_req),
	.stall_i  (stall),
	.wb_we_i  (wb_we_o)
);

// File: tb_mem_subsys.sv
`timescale 1ns/1ps
`include "mem_cfg.svh"

module tb_mem_subsys;

	import cpu_pkg::*;

	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 4;
	localparam int RAND_OPS     = 200;
	localparam int ADDR_BITS    = $clog2(`MEM_DEPTH_WORDS) + 2;
	localparam int TOTAL_OPS    = 1 + `MEM_DEPTH_WORDS + 4 * 10 + 4 + 8 + RAND_OPS;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + TOTAL_OPS * (20 + `MEM_WAIT_STATES);
	localparam oper_t OFFSET_OPS [10] = '{OP_SB, OP_LW, OP_SH, OP_LW, OP_LB, OP_LBU,
	                                      OP_LH, OP_LHU, OP_LWL, OP_LWR};

	logic      clk;
	logic      rst;
	logic      valid_i;
	oper_t     op_i;
	word_t     base_i;
	logic [15:0] offset_i;
	word_t     rt_i;
	reg_addr_t waddr_i;
	logic      stall_o;
	logic      wb_we_o;
	reg_addr_t wb_waddr_o;
	word_t     wb_wdata_o;
	logic      ll_bit_o;

	logic [31:0]    lfsr;
	word_t          shadow [`MEM_DEPTH_WORDS];
	logic           ll_flag;
	reg_write_req_t exp_q [$];
	logic           ll_q [$];
	string          name_q [$];
	string          test_name;
	int             errors;

	mem_subsys_top mem_subsys_top_inst (
		.clk       (clk),
		.rst       (rst),
		.valid_i   (valid_i),
		.op_i      (op_i),
		.base_i    (base_i),
		.offset_i  (offset_i),
		.rt_i      (rt_i),
		.waddr_i   (waddr_i),
		.stall_o   (stall_o),
		.wb_we_o   (wb_we_o),
		.wb_waddr_o(wb_waddr_o),
		.wb_wdata_o(wb_wdata_o),
		.ll_bit_o  (ll_bit_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ####################
	// Reference model
	// ####################

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit.
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic word_t load_value(input oper_t op, input word_t w, input logic [1:0] o,
	                                     input word_t rt);
		word_t r;
		r = rt;
		case (op)
			OP_LB:  r = {{24{w[8*o+7]}}, w[8*o +: 8]};
			OP_LBU: r = {24'b0, w[8*o +: 8]};
			OP_LH:  r = {{16{w[16*o[1]+15]}}, w[16*o[1] +: 16]};
			OP_LHU: r = {16'b0, w[16*o[1] +: 16]};
			// Memory lanes 0 to o fill register lanes 3-o to 3.
			OP_LWL:
				for (int k = 0; k <= o; k++)
					r[8*(k+3-o) +: 8] = w[8*k +: 8];
			OP_LWR:
				for (int k = o; k < 4; k++)
					r[8*(k-o) +: 8] = w[8*k +: 8];
			default: r = w;
		endcase
		return r;
	endfunction

	task automatic expect_result(input oper_t op, input word_t addr, input word_t rt,
	                             input reg_addr_t rd);
		reg_write_req_t e;
		int             idx;
		logic           push;
		idx     = int'(addr >> 2);
		push    = !(op inside {OP_NOP, OP_SB, OP_SH, OP_SW});
		e.we    = 1'b1;
		e.waddr = rd;
		e.wdata = load_value(op, shadow[idx], addr[1:0], rt);
		case (op)
			OP_SB: shadow[idx][8*addr[1:0] +: 8] = rt[7:0];
			OP_SH: shadow[idx][16*addr[1] +: 16] = rt[15:0];
			OP_SW: shadow[idx] = rt;
			OP_LL: ll_flag = 1'b1;
			OP_ALU: e.wdata = rt;
			OP_SC:
			begin
				e.wdata = {31'b0, ll_flag};
				if (ll_flag)
					shadow[idx] = rt;
				ll_flag = 1'b0;
			end
			default: ;
		endcase
		if (push)
		begin
			exp_q.push_back(e);
			ll_q.push_back(ll_flag);
			name_q.push_back(test_name);
		end
	endtask

	// Held until an edge sees stall_o low.
	task automatic issue_op(input oper_t op, input word_t addr, input word_t rt);
		logic [15:0] off;
		reg_addr_t   rd;
		logic        accepted;
		off      = 16'(next_bits(16));
		rd       = reg_addr_t'(next_bits(5));
		valid_i  = (op != OP_NOP);
		op_i     = op;
		offset_i = off;
		base_i   = addr - {{16{off[15]}}, off};
		rt_i     = rt;
		waddr_i  = rd;
		expect_result(op, addr, rt, rd);
		do
		begin
			@(negedge clk);
			accepted = !stall_o;
			@(posedge clk);
		end
		while (!accepted);
		#1;
	endtask

	task automatic check_writeback();
		reg_write_req_t act;
		reg_write_req_t e;
		logic           exp_ll;
		string          name;
		act = {wb_we_o, wb_waddr_o, wb_wdata_o};
		if (exp_q.size() == 0)
		begin
			errors++;
			$display("Write-back to r%0d arrived with no instruction waiting for it",
			         wb_waddr_o);
		end
		else
		begin
			e      = exp_q.pop_front();
			exp_ll = ll_q.pop_front();
			name   = name_q.pop_front();
			assert (act == e)
			else
			begin
				errors++;
				$display("[ERROR] %s: expected r%0d=%h, actual r%0d=%h",
				         name, e.waddr, e.wdata, act.waddr, act.wdata);
			end
			// The LL bit moves at the same edge as the write-back.
			assert (ll_bit_o == exp_ll)
			else
			begin
				errors++;
				$display("[ERROR] %s: expected ll_bit=%0b, actual ll_bit=%0b",
				         name, exp_ll, ll_bit_o);
			end
		end
	endtask

	always @(negedge clk)
	begin
		if (!rst && wb_we_o)
			check_writeback();
	end

	// ####################
	// Stimulus
	// ####################

	initial
	begin
		word_t w;
		int    afails;
		lfsr      = 32'hf683ebd5;
		ll_flag   = 1'b0;
		errors    = 0;
		test_name = "reset";
		rst       = 1'b1;
		valid_i   = 1'b0;
		op_i      = OP_NOP;
		base_i    = '0;
		offset_i  = '0;
		rt_i      = '0;
		waddr_i   = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
		test_name = "sc_after_reset";
		issue_op(OP_SC, '0, next_bits(32));
		test_name = "fill";
		for (int i = 0; i < `MEM_DEPTH_WORDS; i++)
			issue_op(OP_SW, word_t'(i * 4), next_bits(32));
		test_name = "offset_loads_stores";
		for (int o = 0; o < 4; o++)
		begin
			w = next_bits(ADDR_BITS) & ~32'h3;
			foreach (OFFSET_OPS[j])
				issue_op(OFFSET_OPS[j], w + word_t'(o), next_bits(32));
		end
		test_name = "ll_sc";
		w = next_bits(ADDR_BITS) & ~32'h3;
		issue_op(OP_LL, w, '0);
		issue_op(OP_SC, w, next_bits(32));
		issue_op(OP_SC, w, next_bits(32));
		issue_op(OP_LW, w, '0);
		test_name = "alu_pass";
		repeat (8)
		begin
			issue_op(OP_ALU, '0, next_bits(32));
			// An ALU op now sits in EX/MEM.
			assert (!stall_o)
			else
			begin
				errors++;
				$display("An ALU operation in the memory stage raised stall");
			end
		end
		test_name = "random";
		repeat (RAND_OPS)
			issue_op(oper_t'(4'(next_bits(4) % 14)), next_bits(ADDR_BITS), next_bits(32));
		valid_i = 1'b0;
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (4 + `MEM_WAIT_STATES) @(posedge clk);
		afails = mem_subsys_top_inst.mem_subsys_assertions_inst.fail_count;
		$display("Errors: %0d write-back, %0d assertion", errors, afails);
		if (errors == 0 && afails == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog timeout with %0d write-backs outstanding", exp_q.size());
		$display("Test failed");
		$finish;
	end

endmodule

// File: src.f
+incdir+.
cpu_pkg.sv
mem_addr_gen.sv
cpu_mem.sv
data_sram.sv
mem_wb_stage.sv
mem_subsys_top.sv
mem_subsys_assertions.sv
tb_mem_subsys.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_subsys -f src.f
./obj_dir/Vtb_mem_subsys +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
if grep -q "^Test completed successfully$" sim.log
then
	echo "simulation PASS"
else
	echo "simulation FAIL"
	exit 1
fi
